// ==== design/execPkg.sv ====
package execPkg;

   localparam int msrWidth = 4;   // BIP, C, IE, BE

   typedef enum logic [5:0] {
      addOp   = 6'h00,
      rsubOp  = 6'h01,
      addcOp  = 6'h02,
      addiOp  = 6'h08,
      rsubiOp = 6'h09,
      addciOp = 6'h0A,
      bsOp    = 6'h11,
      bsiOp   = 6'h19,
      orOp    = 6'h20,
      andOp   = 6'h21,
      xorOp   = 6'h22,
      andnOp  = 6'h23,
      shiftOp = 6'h24,   // sra, src, srl, sext8, sext16
      msrOp   = 6'h25,   // mfs, mts
      oriOp   = 6'h28,
      andiOp  = 6'h29,
      xoriOp  = 6'h2A,
      andniOp = 6'h2B,
      sbOp    = 6'h34,
      shOp    = 6'h35,
      swOp    = 6'h36,
      sbiOp   = 6'h3C,
      shiOp   = 6'h3D,
      swiOp   = 6'h3E
   } opcode_e;

   typedef struct packed {
      opcode_e     opcode;
      logic [4:0]  rd;
      logic [4:0]  ra;
      logic [4:0]  rb;
      logic [10:0] func;
   } typeA_t;

   typedef struct packed {
      opcode_e     opcode;
      logic [4:0]  rd;
      logic [4:0]  ra;
      logic [15:0] imm;
   } typeB_t;

   // Opcode bit 3 picks the view
   typedef union packed {
      typeA_t a;
      typeB_t b;
   } instrWord_u;

   typedef enum logic [2:0] {
      selAdd    = 3'd0,
      selLogic  = 3'd1,
      selShift  = 3'd2,
      selMove   = 3'd3,
      selBarrel = 3'd4
   } aluSel_e;

   // Operand B source
   localparam logic [1:0] srcReg = 2'd0;
   localparam logic [1:0] srcFwd = 2'd1;
   localparam logic [1:0] srcImm = 2'd2;

   // Single-bit shift modes, as in func bits 6:5
   localparam logic [1:0] shSra  = 2'd0;
   localparam logic [1:0] shSrc  = 2'd1;
   localparam logic [1:0] shSrl  = 2'd2;
   localparam logic [1:0] shSext = 2'd3;

   localparam logic [1:0] movMfs  = 2'd0;
   localparam logic [1:0] movMfpc = 2'd1;
   localparam logic [1:0] movMts  = 2'd2;

   localparam logic [1:0] stByte = 2'd0;
   localparam logic [1:0] stHalf = 2'd1;
   localparam logic [1:0] stWord = 2'd2;

   typedef struct packed {
      logic        valid;
      aluSel_e     aluSel;
      logic        fwdA;        // Operand A from last result
      logic [1:0]  srcB;
      logic        fwdS;        // Store data from last result
      logic [31:0] imm;
      logic        sub;
      logic        useCarry;
      logic [1:0]  logicOp;
      logic [1:0]  shiftMode;
      logic        sextHalf;
      logic [1:0]  barrelMode;  // Bit 1 left, bit 0 arithmetic
      logic [1:0]  moveKind;
      logic        store;
      logic [1:0]  storeSize;
      logic [4:0]  rd;
      logic        we;
   } execCtl_t;

   typedef struct packed {
      logic        strobe;
      logic [31:0] addr;
      logic [3:0]  sel;
      logic [31:0] data;
   } busReq_t;

endpackage

// ==== design/instrDecode.sv ====
`timescale 1ns/1ps

module instrDecode
   import execPkg::*;
#(
   parameter bit useBarrel = 1'b1
) (
   input  logic       gclk,
   input  logic       grst,
   input  logic       instrStb,
   input  instrWord_u instrWord,
   output execCtl_t   ctl,
   output logic [4:0] raAddr,
   output logic [4:0] rbAddr,
   output logic [4:0] rsAddr
);

   logic       isImm;
   logic [4:0] prevRd;
   logic       prevWe;   // Last cycle held a writing instruction
   logic       fwdOk;

   assign isImm  = instrWord.a.opcode[3];

   // Register fields sit at the same bits in both views
   assign raAddr = instrWord.a.ra;
   assign rbAddr = instrWord.a.rb;
   assign rsAddr = instrWord.a.rd;   // Also the store data source

   // r0 is never forwarded
   assign fwdOk = instrStb && prevWe && (prevRd != 5'd0);

   always_comb begin
      ctl        = '0;
      ctl.valid  = instrStb;
      ctl.aluSel = selAdd;
      ctl.rd     = rsAddr;
      ctl.fwdA   = fwdOk && (raAddr == prevRd);
      ctl.fwdS   = fwdOk && (rsAddr == prevRd);

      if (isImm) begin
         ctl.srcB = srcImm;
         ctl.imm  = {{16{instrWord.b.imm[15]}}, instrWord.b.imm};
      end else if (fwdOk && (rbAddr == prevRd)) begin
         ctl.srcB = srcFwd;
      end else begin
         ctl.srcB = srcReg;
      end

      case (instrWord.a.opcode)
         addOp, rsubOp, addcOp, addiOp, rsubiOp, addciOp: begin
            ctl.sub      = instrWord.a.opcode[0];
            ctl.useCarry = instrWord.a.opcode[1];
            ctl.we       = 1'b1;
         end
         orOp, andOp, xorOp, andnOp, oriOp, andiOp, xoriOp, andniOp: begin
            ctl.aluSel  = selLogic;
            ctl.logicOp = instrWord.a.opcode[1:0];
            ctl.we      = 1'b1;
         end
         shiftOp: begin
            ctl.aluSel    = selShift;
            ctl.shiftMode = instrWord.a.func[6:5];
            ctl.sextHalf  = instrWord.a.func[0];
            ctl.we        = 1'b1;
         end
         bsOp, bsiOp: begin
            if (useBarrel) begin
               ctl.aluSel     = selBarrel;
               ctl.barrelMode = instrWord.a.func[10:9];
               ctl.we         = 1'b1;
            end
         end
         msrOp: begin
            ctl.aluSel = selMove;
            // Word bit 14 sits in the rb field of the A view
            if (instrWord.a.rb[3]) begin
               ctl.moveKind = movMts;
            end else begin
               ctl.moveKind = instrWord.a.func[0] ? movMfs : movMfpc;
               ctl.we       = 1'b1;
            end
         end
         sbOp, shOp, swOp, sbiOp, shiOp, swiOp: begin
            ctl.store     = 1'b1;
            ctl.storeSize = instrWord.a.opcode[1:0];
         end
         default: ;   // Unknown opcodes pass as no-ops
      endcase
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         prevRd <= '0;
         prevWe <= 1'b0;
      end else begin
         prevRd <= ctl.rd;
         prevWe <= instrStb && ctl.we;
      end
   end

   validFollowsStb: assert property (@(posedge gclk) disable iff (grst)
      ctl.valid == instrStb);

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/1ps

module regFile (
   input  logic        gclk,
   input  logic        grst,
   input  logic [4:0]  raAddr,
   input  logic [4:0]  rbAddr,
   input  logic [4:0]  rsAddr,
   output logic [31:0] rdA,
   output logic [31:0] rdB,
   output logic [31:0] rdS,
   input  logic        wrEn,
   input  logic [4:0]  wrAddr,
   input  logic [31:0] wrData
);

   logic [31:0] regs [1:31];   // r0 has no storage

   always_ff @(posedge gclk) begin
      if (grst) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn && (wrAddr != 5'd0)) begin
         regs[wrAddr] <= wrData;
      end
   end

   assign rdA = (raAddr == 5'd0) ? '0 : regs[raAddr];
   assign rdB = (rbAddr == 5'd0) ? '0 : regs[rbAddr];
   assign rdS = (rsAddr == 5'd0) ? '0 : regs[rsAddr];

   r0StaysZero: assert property (@(posedge gclk) disable iff (grst)
      (wrEn && wrAddr == 5'd0) |=> (raAddr != 5'd0 || rdA == '0) &&
                                    (rbAddr != 5'd0 || rdB == '0));

endmodule

// ==== design/execUnit.sv ====
`timescale 1ns/1ps

module execUnit
   import execPkg::*;
#(
   parameter bit useBarrel = 1'b1
) (
   input  logic        gclk,
   input  logic        grst,
   input  execCtl_t    ctl,
   input  logic [31:0] rdA,
   input  logic [31:0] rdB,
   input  logic [31:0] rdS,
   input  logic [31:0] pcIn,
   input  logic        msrC,
   input  logic [31:0] msrWord,
   output logic [31:0] result,
   output logic        resValid,
   output logic [4:0]  resRd,
   output logic        wrEn,
   output logic [4:0]  wrAddr,
   output logic [31:0] wrData,
   output logic        carryOut,
   output logic        shiftCarry,
   output execCtl_t    exCtl,
   output logic [31:0] sum,
   output logic [31:0] opA,
   output logic [31:0] storeData
);

   logic [31:0] opB;
   logic [31:0] pcQ;
   logic [31:0] addA;
   logic        cin;
   logic [31:0] logicRes;
   logic [31:0] shiftRes;
   logic [31:0] barrelRes;
   logic [31:0] moveRes;
   logic [31:0] nxtResult;   // Also the forwarding source
   logic        nxtValid;

   always_ff @(posedge gclk) begin
      if (grst) begin
         exCtl <= '0;
      end else begin
         exCtl <= ctl;
      end
   end

   // Operand capture on the strobe edge
   always_ff @(posedge gclk) begin
      if (ctl.valid) begin
         opA <= ctl.fwdA ? nxtResult : rdA;
         case (ctl.srcB)
            srcFwd:  opB <= nxtResult;
            srcImm:  opB <= ctl.imm;
            default: opB <= rdB;
         endcase
         storeData <= ctl.fwdS ? nxtResult : rdS;
         pcQ       <= pcIn;
      end
   end

   // rsub computes rB + ~rA + 1
   assign addA = exCtl.sub ? ~opA : opA;
   assign cin  = exCtl.useCarry ? msrC : exCtl.sub;
   assign {carryOut, sum} = {1'b0, addA} + {1'b0, opB} + {32'd0, cin};

   always_comb begin
      case (exCtl.logicOp)
         2'd0:    logicRes = opA | opB;
         2'd1:    logicRes = opA & opB;
         2'd2:    logicRes = opA ^ opB;
         default: logicRes = opA & ~opB;   // andn
      endcase
   end

   always_comb begin
      shiftCarry = opA[0];
      case (exCtl.shiftMode)
         shSra: shiftRes = {opA[31], opA[31:1]};
         shSrc: shiftRes = {msrC, opA[31:1]};   // Rotate through carry
         shSrl: shiftRes = {1'b0, opA[31:1]};
         default: begin
            shiftCarry = msrC;   // Sign extension leaves C alone
            if (exCtl.sextHalf) begin
               shiftRes = {{16{opA[15]}}, opA[15:0]};
            end else begin
               shiftRes = {{24{opA[7]}}, opA[7:0]};
            end
         end
      endcase
   end

   generate
      if (useBarrel) begin : gBarrel
         always_comb begin
            case (exCtl.barrelMode)
               2'b00:   barrelRes = opA >> opB[4:0];
               2'b01:   barrelRes = $unsigned($signed(opA) >>> opB[4:0]);
               default: barrelRes = opA << opB[4:0];
            endcase
         end
      end else begin : gNoBarrel
         assign barrelRes = '0;
      end
   endgenerate

   always_comb begin
      case (exCtl.moveKind)
         movMfs:  moveRes = msrWord;
         movMfpc: moveRes = pcQ;
         default: moveRes = opA;   // mts, nothing written back
      endcase
   end

   always_comb begin
      case (exCtl.aluSel)
         selLogic:  nxtResult = logicRes;
         selShift:  nxtResult = shiftRes;
         selMove:   nxtResult = moveRes;
         selBarrel: nxtResult = barrelRes;
         default:   nxtResult = sum;
      endcase
   end

   assign nxtValid = exCtl.valid && exCtl.we;

   always_ff @(posedge gclk) begin
      if (grst) begin
         result   <= '0;
         resValid <= 1'b0;
         resRd    <= '0;
      end else begin
         resValid <= nxtValid;
         if (nxtValid) begin
            result <= nxtResult;
            resRd  <= exCtl.rd;
         end
      end
   end

   // Write-back lands on the same edge as the result register
   assign wrEn   = nxtValid;
   assign wrAddr = exCtl.rd;
   assign wrData = nxtResult;

   noBarrelSel: assert property (@(posedge gclk) disable iff (grst)
      !useBarrel |-> !(exCtl.valid && exCtl.aluSel == selBarrel));

endmodule

// ==== design/msrUnit.sv ====
`timescale 1ns/1ps

module msrUnit
   import execPkg::*;
(
   input  logic        gclk,
   input  logic        grst,
   input  execCtl_t    exCtl,
   input  logic        carryOut,
   input  logic        shiftCarry,
   input  logic [31:0] opA,
   output logic        msrC,
   output logic        msrIe,
   output logic [31:0] msrWord
);

   logic [msrWidth-1:0] msrQ;   // BIP C IE BE, same order as the word
   logic [msrWidth-1:0] msrNxt;
   logic                isMts;

   assign isMts = exCtl.valid && (exCtl.aluSel == selMove) && (exCtl.moveKind == movMts);

   always_comb begin
      msrNxt = msrQ;
      if (isMts) begin
         msrNxt = opA[msrWidth-1:0];
      end else if (exCtl.valid) begin
         // Stores and no-ops carry we low so the adder leaves C alone
         if (exCtl.aluSel == selAdd && exCtl.we) begin
            msrNxt[2] = carryOut;
         end else if (exCtl.aluSel == selShift) begin
            msrNxt[2] = shiftCarry;
         end
      end
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         msrQ <= '0;
      end else begin
         msrQ <= msrNxt;
      end
   end

   assign msrC  = msrQ[2];
   assign msrIe = msrQ[1];

   // C copied to the top bit
   assign msrWord = {msrQ[2], {(31 - msrWidth){1'b0}}, msrQ};

endmodule

// ==== design/dataBusPort.sv ====
`timescale 1ns/1ps

module dataBusPort
   import execPkg::*;
(
   input  logic        gclk,
   input  logic        grst,
   input  execCtl_t    exCtl,
   input  logic [31:0] sum,
   input  logic [31:0] storeData,
   output busReq_t     busReq
);

   busReq_t reqNxt;

   // Big-endian lanes, byte 0 on sel bit 3
   always_comb begin
      reqNxt        = '0;
      reqNxt.strobe = exCtl.valid && exCtl.store;
      reqNxt.addr   = sum;
      case (exCtl.storeSize)
         stByte: begin
            reqNxt.data = {4{storeData[7:0]}};
            case (sum[1:0])
               2'd0:    reqNxt.sel = 4'h8;
               2'd1:    reqNxt.sel = 4'h4;
               2'd2:    reqNxt.sel = 4'h2;
               default: reqNxt.sel = 4'h1;
            endcase
         end
         stHalf: begin
            reqNxt.data = {2{storeData[15:0]}};
            reqNxt.sel  = sum[1] ? 4'h3 : 4'hC;
         end
         default: begin
            reqNxt.data = storeData;
            reqNxt.sel  = 4'hF;
         end
      endcase
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         busReq <= '0;
      end else if (reqNxt.strobe) begin
         busReq <= reqNxt;
      end else begin
         busReq.strobe <= 1'b0;   // Payload holds between stores
      end
   end

   legalSel: assert property (@(posedge gclk) disable iff (grst)
      busReq.strobe |-> busReq.sel inside {4'h8, 4'h4, 4'h2, 4'h1, 4'hC, 4'h3, 4'hF});

endmodule

// ==== design/execCore.sv ====
`timescale 1ns/1ps

module execCore
   import execPkg::*;
#(
   parameter bit useBarrel = 1'b1
) (
   input  logic        gclk,
   input  logic        grst,
   input  logic        instrStb,
   input  instrWord_u  instrWord,
   input  logic [31:0] pcIn,
   output logic        resValid,
   output logic [31:0] result,
   output logic [4:0]  resRd,
   output logic        msrIe,
   output busReq_t     busReq
);

   execCtl_t    ctl;
   execCtl_t    exCtl;
   logic [4:0]  raAddr;
   logic [4:0]  rbAddr;
   logic [4:0]  rsAddr;
   logic [31:0] rdA;
   logic [31:0] rdB;
   logic [31:0] rdS;
   logic        wrEn;
   logic [4:0]  wrAddr;
   logic [31:0] wrData;
   logic        msrC;
   logic [31:0] msrWord;
   logic        carryOut;
   logic        shiftCarry;
   logic [31:0] sum;
   logic [31:0] opA;
   logic [31:0] storeData;

   instrDecode #(.useBarrel(useBarrel)) decode (
      .gclk(gclk), .grst(grst), .instrStb(instrStb), .instrWord(instrWord),
      .ctl(ctl), .raAddr(raAddr), .rbAddr(rbAddr), .rsAddr(rsAddr)
   );

   regFile regs (
      .gclk(gclk), .grst(grst),
      .raAddr(raAddr), .rbAddr(rbAddr), .rsAddr(rsAddr),
      .rdA(rdA), .rdB(rdB), .rdS(rdS),
      .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
   );

   execUnit #(.useBarrel(useBarrel)) exec (
      .gclk(gclk), .grst(grst), .ctl(ctl),
      .rdA(rdA), .rdB(rdB), .rdS(rdS), .pcIn(pcIn),
      .msrC(msrC), .msrWord(msrWord),
      .result(result), .resValid(resValid), .resRd(resRd),
      .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
      .carryOut(carryOut), .shiftCarry(shiftCarry), .exCtl(exCtl),
      .sum(sum), .opA(opA), .storeData(storeData)
   );

   msrUnit msr (
      .gclk(gclk), .grst(grst), .exCtl(exCtl),
      .carryOut(carryOut), .shiftCarry(shiftCarry), .opA(opA),
      .msrC(msrC), .msrIe(msrIe), .msrWord(msrWord)
   );

   dataBusPort dbus (
      .gclk(gclk), .grst(grst), .exCtl(exCtl),
      .sum(sum), .storeData(storeData), .busReq(busReq)
   );

endmodule

// ==== verification/execCoreTb.sv ====
`timescale 1ns/1ps

module execCoreTb
   import execPkg::*;
();

   localparam int clkPeriod      = 8;
   localparam int perTest        = 200;
   localparam int numTests       = 6;
   localparam int watchdogCycles = numTests * (perTest + 16) + 64;

   typedef struct packed {
      logic        valid;
      logic [31:0] res;
      logic [4:0]  rd;
      logic        ie;
      logic        stb;
      logic [31:0] addr;
      logic [3:0]  sel;
      logic [31:0] data;
   } expect_t;

   logic        gclk;
   logic        grst;
   logic        instrStb;
   instrWord_u  instrWord;
   logic [31:0] pcIn;
   logic        resValid;
   logic [31:0] result;
   logic [4:0]  resRd;
   logic        msrIe;
   busReq_t     busReq;

   logic [31:0] mRegs [0:31];   // Reference register file
   logic        mC;
   logic        mIe;
   logic        mBip;
   logic        mBe;
   expect_t     exp1;
   expect_t     exp2;            // Due on the outputs at the next edge
   string       testName;
   int          errCount;
   int          issued;

   execCore #(.useBarrel(1'b1)) uut (
      .gclk(gclk), .grst(grst), .instrStb(instrStb), .instrWord(instrWord),
      .pcIn(pcIn), .resValid(resValid), .result(result), .resRd(resRd),
      .msrIe(msrIe), .busReq(busReq)
   );

   initial begin
      gclk = 1'b0;
      forever #(clkPeriod / 2) gclk = ~gclk;
   end

   function automatic logic [31:0] wordA(input logic [5:0] op, input logic [4:0] rd,
                                         input logic [4:0] ra, input logic [4:0] rb,
                                         input logic [10:0] fn);
      return {op, rd, ra, rb, fn};
   endfunction

   function automatic logic [31:0] wordB(input logic [5:0] op, input logic [4:0] rd,
                                         input logic [4:0] ra, input logic [15:0] imm);
      return {op, rd, ra, imm};
   endfunction

   // Kinds: 0 arith, 1 logic/shift/barrel, 2 both mixed, 3 status moves, 4 stores
   function automatic logic [31:0] randomInstr(input int kind, input int maxReg);
      logic [4:0]  rd;
      logic [4:0]  ra;
      logic [4:0]  rb;
      logic [15:0] imm;
      logic        isImm;
      logic [1:0]  mode;
      int          pick;
      int          cls;
      rd    = 5'($urandom % (maxReg + 1));
      ra    = 5'($urandom % (maxReg + 1));
      rb    = 5'($urandom % (maxReg + 1));
      imm   = 16'($urandom);
      isImm = 1'($urandom);
      pick  = $urandom % 4;
      cls   = (kind == 2) ? $urandom % 2 : kind;
      if ((cls == 3 || cls == 4) && pick == 0) begin
         return wordB(addiOp, rd, ra, imm);   // Loads fresh values into registers
      end
      case (cls)
         0: return isImm ? wordB({2'b00, 1'b1, 1'b0, 2'($urandom % 3)}, rd, ra, imm)
                         : wordA({2'b00, 1'b0, 1'b0, 2'($urandom % 3)}, rd, ra, rb, 11'd0);
         1: begin
            mode = 2'($urandom % 3);
            if (pick == 0) begin
               case ($urandom % 5)
                  0: return wordA(shiftOp, rd, ra, 5'd0, 11'h001);
                  1: return wordA(shiftOp, rd, ra, 5'd0, 11'h021);
                  2: return wordA(shiftOp, rd, ra, 5'd0, 11'h041);
                  3: return wordA(shiftOp, rd, ra, 5'd0, 11'h060);
                  default: return wordA(shiftOp, rd, ra, 5'd0, 11'h061);
               endcase
            end else if (pick == 1) begin
               return isImm ? wordB(bsiOp, rd, ra, {5'd0, mode, 4'd0, imm[4:0]})
                            : wordA(bsOp, rd, ra, rb, {mode, 9'd0});
            end
            return isImm ? wordB({2'b10, 1'b1, 1'b0, imm[15:14]}, rd, ra, imm)
                         : wordA({2'b10, 1'b0, 1'b0, imm[15:14]}, rd, ra, rb, 11'd0);
         end
         3: begin
            if (pick == 1) return wordA(msrOp, 5'd0, ra, 5'b01000, 11'd0);   // mts
            return wordA(msrOp, rd, 5'd0, 5'd0, {10'd0, pick == 2});         // mfs or mfpc
         end
         default: return isImm ? wordB({3'b110, 1'b1, 2'($urandom % 3)}, rd, ra, imm)
                               : wordA({3'b110, 1'b0, 2'($urandom % 3)}, rd, ra, rb, 11'd0);
      endcase
   endfunction

   always @(posedge gclk) begin : refModel
      expect_t     e;
      logic [31:0] w;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] r;
      logic [31:0] d;
      logic [32:0] wide;
      logic        wr;
      if (grst) begin
         for (int i = 0; i < 32; i++) begin
            mRegs[i] = '0;
         end
         {mBip, mC, mIe, mBe} = 4'b0000;
         exp1 <= '0;
         exp2 <= '0;
      end else begin
         e  = '0;
         r  = '0;
         wr = 1'b0;
         w  = instrWord;
         a  = mRegs[w[20:16]];
         b  = w[29] ? {{16{w[15]}}, w[15:0]} : mRegs[w[15:11]];   // Bit 29 marks immediate
         if (instrStb) begin
            case (w[31:26])
               addOp, addcOp, addiOp, addciOp: begin
                  wide = {1'b0, a} + {1'b0, b} + {32'd0, (w[27] ? mC : 1'b0)};
                  r    = wide[31:0];
                  mC   = wide[32];
                  wr   = 1'b1;
               end
               rsubOp, rsubiOp: begin
                  r  = b - a;
                  mC = (b >= a);   // Carry means no borrow
                  wr = 1'b1;
               end
               orOp, andOp, xorOp, andnOp, oriOp, andiOp, xoriOp, andniOp: begin
                  case (w[27:26])
                     2'd0:    r = a | b;
                     2'd1:    r = a & b;
                     2'd2:    r = a ^ b;
                     default: r = a & ~b;
                  endcase
                  wr = 1'b1;
               end
               shiftOp: begin
                  case (w[6:5])
                     2'd0:    r = {a[31], a[31:1]};
                     2'd1:    r = {mC, a[31:1]};
                     2'd2:    r = {1'b0, a[31:1]};
                     default: r = w[0] ? {{16{a[15]}}, a[15:0]} : {{24{a[7]}}, a[7:0]};
                  endcase
                  if (w[6:5] != 2'd3) begin
                     mC = a[0];
                  end
                  wr = 1'b1;
               end
               bsOp, bsiOp: begin
                  if (w[10]) begin
                     r = a << b[4:0];
                  end else if (w[9]) begin
                     r = $signed(a) >>> b[4:0];
                  end else begin
                     r = a >> b[4:0];
                  end
                  wr = 1'b1;
               end
               msrOp: begin
                  if (w[14]) begin
                     {mBip, mC, mIe, mBe} = a[3:0];
                  end else begin
                     r  = w[0] ? {mC, 27'd0, mBip, mC, mIe, mBe} : pcIn;
                     wr = 1'b1;
                  end
               end
               sbOp, shOp, swOp, sbiOp, shiOp, swiOp: begin
                  d      = mRegs[w[25:21]];
                  e.stb  = 1'b1;
                  e.addr = a + b;
                  case (w[27:26])
                     2'd0: begin
                        e.sel  = 4'b1000 >> e.addr[1:0];
                        e.data = {4{d[7:0]}};
                     end
                     2'd1: begin
                        e.sel  = e.addr[1] ? 4'b0011 : 4'b1100;
                        e.data = {2{d[15:0]}};
                     end
                     default: begin
                        e.sel  = 4'b1111;
                        e.data = d;
                     end
                  endcase
               end
               default: ;
            endcase
            e.valid = wr;
            e.res   = r;
            e.rd    = w[25:21];
            if (wr && w[25:21] != 5'd0) begin
               mRegs[w[25:21]] = r;
            end
         end
         e.ie = mIe;
         exp1 <= e;
         exp2 <= exp1;
      end
   end

   validOk: assert property (@(posedge gclk) disable iff (grst) resValid == exp2.valid)
      else begin
         errCount++;
         $display("ERROR %s resValid expected %0b actual %0b", testName,
                  $sampled(exp2.valid), $sampled(resValid));
      end

   resultOk: assert property (@(posedge gclk) disable iff (grst)
      exp2.valid |-> (result == exp2.res && resRd == exp2.rd))
      else begin
         errCount++;
         $display("ERROR %s result expected r%0d=%h actual r%0d=%h", testName,
                  $sampled(exp2.rd), $sampled(exp2.res), $sampled(resRd), $sampled(result));
      end

   ieOk: assert property (@(posedge gclk) disable iff (grst) msrIe == exp2.ie)
      else begin
         errCount++;
         $display("ERROR %s msrIe expected %0b actual %0b", testName,
                  $sampled(exp2.ie), $sampled(msrIe));
      end

   busStbOk: assert property (@(posedge gclk) disable iff (grst) busReq.strobe == exp2.stb)
      else begin
         errCount++;
         $display("ERROR %s bus strobe expected %0b actual %0b", testName,
                  $sampled(exp2.stb), $sampled(busReq.strobe));
      end

   busReqOk: assert property (@(posedge gclk) disable iff (grst)
      exp2.stb |-> (busReq.addr == exp2.addr && busReq.sel == exp2.sel &&
                    busReq.data == exp2.data))
      else begin
         errCount++;
         $display("ERROR %s bus addr/sel/data expected %h/%h/%h actual %h/%h/%h", testName,
                  $sampled(exp2.addr), $sampled(exp2.sel), $sampled(exp2.data),
                  $sampled(busReq.addr), $sampled(busReq.sel), $sampled(busReq.data));
      end

   task automatic step(input logic stb, input logic [31:0] word);
      @(posedge gclk);
      instrStb  <= stb;
      instrWord <= word;
      pcIn      <= pcIn + 32'd4;
   endtask

   task automatic holdReset();
      grst     <= 1'b1;
      instrStb <= 1'b0;
      repeat (3) @(posedge gclk);
      grst <= 1'b0;
   endtask

   task automatic runTest(input string name, input int kind, input int maxReg, input bit dense);
      int startErrs;
      int count;
      startErrs = errCount;
      count     = 0;
      testName  = name;
      for (int i = 0; i < perTest; i++) begin
         if (!dense && ($urandom % 4 == 0)) begin
            step(1'b0, $urandom);   // Idle slot with a junk word
         end else begin
            step(1'b1, randomInstr(kind, maxReg));
            count++;
         end
      end
      repeat (4) step(1'b0, $urandom);
      issued += count;
      $display("Test %s done: %0d instructions, %0d errors", name, count, errCount - startErrs);
   endtask

   initial begin
      int startErrs;
      void'($urandom(32'h615d_9d98));
      grst      = 1'b1;
      instrStb  = 1'b0;
      instrWord = '0;
      pcIn      = 32'h0000_1000;
      errCount  = 0;
      issued    = 0;
      testName  = "startup";
      holdReset();
      runTest("arithmetic", 0, 7, 1'b0);
      runTest("logicShift", 1, 7, 1'b0);
      runTest("forwarding", 2, 3, 1'b1);   // Few registers, strobe every cycle
      runTest("statusReg", 3, 7, 1'b0);
      runTest("stores", 4, 7, 1'b0);

      // Set IE so the reset has something to clear
      testName  = "reset";
      startErrs = errCount;
      step(1'b1, wordB(addiOp, 5'd1, 5'd0, 16'h0002));
      step(1'b1, wordA(msrOp, 5'd0, 5'd1, 5'b01000, 11'd0));
      repeat (4) step(1'b0, $urandom);
      holdReset();
      repeat (8) step(1'b0, $urandom);
      issued += 2;
      $display("Test reset done: 2 instructions, %0d errors", errCount - startErrs);

      $display("Tests %0d, instructions %0d, errors %0d", numTests, issued, errCount);
      if (errCount == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      #(watchdogCycles * clkPeriod);
      $display("Watchdog expired after %0d cycles before the tests finished", watchdogCycles);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// ==== execCore.f ====
design/execPkg.sv
design/instrDecode.sv
design/regFile.sv
design/execUnit.sv
design/msrUnit.sv
design/dataBusPort.sv
design/execCore.sv
verification/execCoreTb.sv
